// File: logic/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

//////////////////////////////////////////////////
// memory subsystem sizing
//////////////////////////////////////////////////

// reorder-buffer tag width, tag 0 is reserved
`define LSB_TAG_W 3

// queue depths
`define FETCH_DEPTH 8
`define COMMIT_DEPTH 8

// byte ram decodes this many address bits
`define RAM_ADDR_W 12

`endif

// File: logic/lsu_pkg.sv
`include "mem_settings.svh"

package lsu_pkg;

    typedef logic [`LSB_TAG_W-1:0] rob_tag_t;
    typedef logic [31:0] mem_word_t;
    typedef logic [7:0] byte_t;

    localparam rob_tag_t TAG_NONE = '0;

    // memory opcodes only, alu and branch ops live elsewhere
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } mem_op_t;

    function automatic logic is_store_op(input mem_op_t op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

    // index of the last byte touched by op
    function automatic logic [1:0] op_last_byte(input mem_op_t op);
        case (op)
            LH, LHU, SH: return 2'd1;
            LW, SW:      return 2'd3;
            default:     return 2'd0;
        endcase
    endfunction

endpackage

// File: logic/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////
    // instruction fetch types
    //////////////////////////////////////////////////

    typedef logic [31:0] pc_t;
    typedef logic [31:0] ins_word_t;

endpackage

// File: logic/ring_queue.sv
`timescale 1ns/1ps

module ring_queue #(
    parameter type T = logic [7:0],
    parameter int DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  T                             push_data,
    input  logic                         pop,
    output T                             head,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   free_slots
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 slots [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + PTR_W'(1);  // wrap for any depth
    endfunction

    assign full       = (count == CNT_W'(DEPTH));
    assign empty      = (count == '0);
    assign do_pop     = pop && !empty;
    assign do_push    = push && (!full || pop);  // full but popping frees a slot
    assign head       = slots[rd_ptr];
    assign free_slots = CNT_W'(DEPTH) - count;

    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // the source is expected to watch free_slots
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
        push |-> (!full || pop))
        else $error("ring_queue push while full");

endmodule

// File: logic/lsb_entry_table.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module lsb_entry_table
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  mem_op_t   issue_op,
    input  rob_tag_t  issue_tag,
    input  mem_word_t issue_addr,
    input  mem_word_t issue_data,
    input  rob_tag_t  look_tag,
    output mem_op_t   look_op,
    output mem_word_t look_addr,
    output mem_word_t look_data,
    output logic      look_busy,
    input  logic      clear,
    input  rob_tag_t  clear_tag
);

    localparam int ENTRIES = 1 << `LSB_TAG_W;

    mem_op_t            op_q   [ENTRIES];
    mem_word_t          addr_q [ENTRIES];
    mem_word_t          data_q [ENTRIES];
    logic [ENTRIES-1:0] busy_q;
    logic               alloc;

    assign alloc = (issue_op != MEM_NONE);

    always_ff @(posedge clk) begin
        if (alloc) begin
            op_q[issue_tag]   <= issue_op;
            addr_q[issue_tag] <= issue_addr;
            data_q[issue_tag] <= issue_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy_q <= '0;
        end else begin
            if (clear) begin
                busy_q[clear_tag] <= 1'b0;
            end
            if (alloc) begin
                busy_q[issue_tag] <= 1'b1;  // reissue of a retiring tag wins
            end
        end
    end

    assign look_op   = op_q[look_tag];
    assign look_addr = addr_q[look_tag];
    assign look_data = data_q[look_tag];
    assign look_busy = busy_q[look_tag];

    //////////////////////////////////////////////////
    // reorder buffer contract
    //////////////////////////////////////////////////

    a_alloc_free_tag: assert property (@(posedge clk) disable iff (!rst)
        alloc |-> (!busy_q[issue_tag] || (clear && clear_tag == issue_tag)))
        else $error("allocation to a busy tag");

    a_alloc_real_tag: assert property (@(posedge clk) disable iff (!rst)
        alloc |-> (issue_tag != TAG_NONE))
        else $error("allocation to tag 0");

endmodule

// File: logic/byte_mem_sequencer.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module byte_mem_sequencer
    import lsu_pkg::*;
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    // committed tags
    input  rob_tag_t               commit_head,
    input  logic                   commit_empty,
    output logic                   commit_pop,
    // fetch addresses
    input  pc_t                    fetch_head,
    input  logic                   fetch_empty,
    output logic                   fetch_pop,
    // entry table
    output rob_tag_t               look_tag,
    input  mem_op_t                look_op,
    input  mem_word_t              look_addr,
    input  mem_word_t              look_data,
    input  logic                   look_busy,
    output logic                   clear,
    output rob_tag_t               clear_tag,
    // byte ram
    output logic [`RAM_ADDR_W-1:0] ram_addr,
    output logic                   ram_we,
    output byte_t                  ram_wdata,
    input  byte_t                  ram_rdata,
    // completions
    output logic                   load_valid,
    output rob_tag_t               load_tag,
    output mem_word_t              load_value,
    output logic                   store_done,
    output rob_tag_t               store_tag,
    output logic                   ins_valid,
    output ins_word_t              ins_value
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACCESS,
        S_WAIT,
        S_DONE
    } seq_state_t;

    seq_state_t             state;
    logic [1:0]             idx;
    logic [1:0]             last_idx;
    logic                   job_fetch;
    logic                   job_store;
    mem_op_t                job_op;
    rob_tag_t               job_tag;
    logic [`RAM_ADDR_W-1:0] job_addr;
    mem_word_t              data_q;  // store data, then the assembled read word
    logic                   rd_valid_q;
    logic [1:0]             rd_idx_q;
    logic                   take_mem;
    logic                   take_fetch;
    logic                   drop_commit;
    logic                   finishing;

    //////////////////////////////////////////////////
    // job selection
    //////////////////////////////////////////////////

    assign look_tag = commit_head;

    always_comb begin
        take_mem    = 1'b0;
        take_fetch  = 1'b0;
        drop_commit = 1'b0;
        if (state == S_IDLE && !stall) begin
            if (!commit_empty && look_busy) begin
                take_mem = 1'b1;  // committed memory op first
            end else begin
                drop_commit = !commit_empty;  // tag never issued or already done
                take_fetch  = !fetch_empty;
            end
        end
    end

    //////////////////////////////////////////////////
    // byte sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= S_IDLE;
            idx        <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= (state == S_ACCESS) && !job_store;  // byte due next cycle
            case (state)
                S_IDLE: begin
                    if (take_mem || take_fetch) begin
                        state <= S_ACCESS;
                        idx   <= '0;
                    end
                end
                S_ACCESS: begin
                    idx <= idx + 2'd1;
                    if (idx == last_idx) begin
                        state <= job_store ? S_DONE : S_WAIT;
                    end
                end
                S_WAIT:  state <= S_DONE;  // last byte on ram_rdata
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rd_idx_q <= idx;
        if (take_mem || take_fetch) begin
            job_fetch <= take_fetch;
            job_store <= take_mem && is_store_op(look_op);
            job_op    <= take_fetch ? MEM_NONE : look_op;
            job_tag   <= commit_head;
            job_addr  <= take_fetch ? fetch_head[`RAM_ADDR_W-1:0]
                                    : look_addr[`RAM_ADDR_W-1:0];
            last_idx  <= take_fetch ? 2'd3 : op_last_byte(look_op);
            data_q    <= look_data;
        end else if (rd_valid_q) begin
            data_q[8*rd_idx_q +: 8] <= ram_rdata;  // little endian placement
        end
    end

    assign ram_addr  = job_addr + `RAM_ADDR_W'(idx);
    assign ram_we    = (state == S_ACCESS) && job_store;
    assign ram_wdata = data_q[8*idx +: 8];

    //////////////////////////////////////////////////
    // completion
    //////////////////////////////////////////////////

    assign finishing  = (state == S_DONE);
    assign commit_pop = drop_commit || (finishing && !job_fetch);
    assign fetch_pop  = finishing && job_fetch;
    assign clear      = finishing && !job_fetch;
    assign clear_tag  = job_tag;

    assign load_valid = finishing && !job_fetch && !job_store;
    assign load_tag   = job_tag;
    assign store_done = finishing && !job_fetch && job_store;
    assign store_tag  = job_tag;
    assign ins_valid  = finishing && job_fetch;
    assign ins_value  = data_q;

    always_comb begin
        case (job_op)
            LB:      load_value = {{24{data_q[7]}}, data_q[7:0]};
            LH:      load_value = {{16{data_q[15]}}, data_q[15:0]};
            LBU:     load_value = {24'h0, data_q[7:0]};
            LHU:     load_value = {16'h0, data_q[15:0]};
            default: load_value = data_q;  // lw
        endcase
    end

    a_fetch_read_only: assert property (@(posedge clk) disable iff (!rst)
        (state != S_IDLE && job_fetch) |-> !ram_we)
        else $error("ram write during an instruction fetch");

endmodule

// File: logic/byte_ram.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module byte_ram
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic [`RAM_ADDR_W-1:0] ram_addr,
    input  logic                   ram_we,
    input  byte_t                  ram_wdata,
    output byte_t                  ram_rdata
);

    localparam int RAM_BYTES = 1 << `RAM_ADDR_W;

    byte_t mem [RAM_BYTES];

    initial begin
        for (int i = 0; i < RAM_BYTES; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
        end
        ram_rdata <= mem[ram_addr];  // old byte on a write cycle
    end

endmodule

// File: logic/mem_subsystem_top.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsystem_top
    import lsu_pkg::*;
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  mem_op_t   issue_op,
    input  rob_tag_t  issue_tag,
    input  mem_word_t issue_addr,
    input  mem_word_t issue_data,
    input  rob_tag_t  commit_tag,
    input  logic      fetch_req,
    input  pc_t       fetch_pc,
    input  logic      stall,
    output logic      load_valid,
    output rob_tag_t  load_tag,
    output mem_word_t load_value,
    output logic      store_done,
    output rob_tag_t  store_tag,
    output logic      ins_valid,
    output ins_word_t ins_value,
    output logic      fetch_full
);

    pc_t                                 fetch_head;
    logic                                fetch_empty;
    logic                                fetch_pop;
    logic [$clog2(`FETCH_DEPTH+1)-1:0]   fetch_free;
    rob_tag_t                            commit_head;
    logic                                commit_empty;
    logic                                commit_pop;
    rob_tag_t                            look_tag;
    mem_op_t                             look_op;
    mem_word_t                           look_addr;
    mem_word_t                           look_data;
    logic                                look_busy;
    logic                                clear;
    rob_tag_t                            clear_tag;
    logic [`RAM_ADDR_W-1:0]              ram_addr;
    logic                                ram_we;
    byte_t                               ram_wdata;
    byte_t                               ram_rdata;

    assign fetch_full = (fetch_free < 2);  // keeps one slot of slack

    ring_queue #(.T(pc_t), .DEPTH(`FETCH_DEPTH)) fetch_queue (
        .clk(clk), .rst(rst),
        .push(fetch_req), .push_data(fetch_pc), .pop(fetch_pop),
        .head(fetch_head), .empty(fetch_empty), .free_slots(fetch_free)
    );

    ring_queue #(.T(rob_tag_t), .DEPTH(`COMMIT_DEPTH)) commit_queue (
        .clk(clk), .rst(rst),
        .push(commit_tag != TAG_NONE), .push_data(commit_tag), .pop(commit_pop),
        .head(commit_head), .empty(commit_empty), .free_slots()
    );

    lsb_entry_table entry_table (
        .clk(clk), .rst(rst),
        .issue_op(issue_op), .issue_tag(issue_tag),
        .issue_addr(issue_addr), .issue_data(issue_data),
        .look_tag(look_tag), .look_op(look_op), .look_addr(look_addr),
        .look_data(look_data), .look_busy(look_busy),
        .clear(clear), .clear_tag(clear_tag)
    );

    byte_mem_sequencer sequencer (
        .clk(clk), .rst(rst), .stall(stall),
        .commit_head(commit_head), .commit_empty(commit_empty), .commit_pop(commit_pop),
        .fetch_head(fetch_head), .fetch_empty(fetch_empty), .fetch_pop(fetch_pop),
        .look_tag(look_tag), .look_op(look_op), .look_addr(look_addr),
        .look_data(look_data), .look_busy(look_busy),
        .clear(clear), .clear_tag(clear_tag),
        .ram_addr(ram_addr), .ram_we(ram_we), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata),
        .load_valid(load_valid), .load_tag(load_tag), .load_value(load_value),
        .store_done(store_done), .store_tag(store_tag),
        .ins_valid(ins_valid), .ins_value(ins_value)
    );

    byte_ram ram (
        .clk(clk), .ram_addr(ram_addr), .ram_we(ram_we),
        .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
    );

endmodule

// File: verif/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb
    import lsu_pkg::*;
    import fetch_pkg::*;
();

    localparam int MAX_CMDS    = 128;
    localparam int LONGEST_JOB = 6;  // lw or fetch, selection to pulse

    logic      clk = 1'b0;
    logic      rst;
    mem_op_t   issue_op;
    rob_tag_t  issue_tag;
    mem_word_t issue_addr;
    mem_word_t issue_data;
    rob_tag_t  commit_tag;
    logic      fetch_req;
    pc_t       fetch_pc;
    logic      stall;
    logic      load_valid;
    rob_tag_t  load_tag;
    mem_word_t load_value;
    logic      store_done;
    rob_tag_t  store_tag;
    logic      ins_valid;
    ins_word_t ins_value;
    logic      fetch_full;

    logic [8*16-1:0] cmd_kind [MAX_CMDS];
    logic [31:0]     cmd_tag  [MAX_CMDS];
    logic [31:0]     cmd_op   [MAX_CMDS];
    logic [31:0]     cmd_addr [MAX_CMDS];
    logic [31:0]     cmd_data [MAX_CMDS];
    logic [31:0]     cmd_exp  [MAX_CMDS];
    int              n_cmds = 0;
    bit              cases_loaded = 1'b0;
    int              errors = 0;
    int              stall_cycles = 0;
    integer          seed = 32'h5240;

    rob_tag_t  load_tags   [$];
    mem_word_t load_values [$];
    rob_tag_t  store_tags  [$];
    ins_word_t ins_values  [$];

    mem_subsystem_top dut (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic int pending();
        return load_tags.size() + store_tags.size() + ins_values.size();
    endfunction

    //////////////////////////////////////////////////
    // result checks
    //////////////////////////////////////////////////

    task automatic check_load(input rob_tag_t got_tag, input mem_word_t got_value);
        rob_tag_t  exp_tag;
        mem_word_t exp_value;
        if (load_tags.size() == 0) begin
            $display("load result with tag %h arrived with none expected", got_tag);
            errors++;
            return;
        end
        exp_tag   = load_tags.pop_front();
        exp_value = load_values.pop_front();
        if (got_tag !== exp_tag) begin
            $display("Error: load_tag got %h expected %h", got_tag, exp_tag);
            errors++;
        end
        if (got_value !== exp_value) begin
            $display("Error: load_value got %h expected %h", got_value, exp_value);
            errors++;
        end
    endtask

    task automatic check_store(input rob_tag_t got_tag);
        rob_tag_t exp_tag;
        if (store_tags.size() == 0) begin
            $display("store done with tag %h arrived with none expected", got_tag);
            errors++;
            return;
        end
        exp_tag = store_tags.pop_front();
        if (got_tag !== exp_tag) begin
            $display("Error: store_tag got %h expected %h", got_tag, exp_tag);
            errors++;
        end
    endtask

    task automatic check_ins(input ins_word_t got_value);
        ins_word_t exp_value;
        if (ins_values.size() == 0) begin
            $display("instruction word %h arrived with none expected", got_value);
            errors++;
            return;
        end
        exp_value = ins_values.pop_front();
        if (got_value !== exp_value) begin
            $display("Error: ins_value got %h expected %h", got_value, exp_value);
            errors++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("Error: %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!stall) begin
            stall_cycles <= 0;
        end else if (stall_cycles < LONGEST_JOB) begin
            stall_cycles <= stall_cycles + 1;
        end
    end

    always @(negedge clk) begin  // mid-cycle, outputs settled
        if (!rst) begin
            if ({load_valid, store_done, ins_valid, fetch_full} !== 4'b0) begin
                $display("completion or fetch_full active during reset at %0t", $time);
                errors++;
            end
        end else begin
            if (stall_cycles >= LONGEST_JOB && (load_valid || store_done || ins_valid)) begin
                $display("completion pulse while stalled at %0t", $time);
                errors++;
            end
            if (load_valid) check_load(load_tag, load_value);
            if (store_done) check_store(store_tag);
            if (ins_valid) check_ins(ins_value);
        end
    end

    //////////////////////////////////////////////////
    // case file
    //////////////////////////////////////////////////

    task automatic read_cases();
        int               fd;
        int               n;
        logic [8*16-1:0]  kind;
        logic [8*120-1:0] rest;
        logic [31:0]      tag;
        logic [31:0]      op;
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [31:0]      expv;
        fd = $fopen("verif/mem_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/mem_cases.txt");
            return;
        end
        kind = '0;
        while ($fscanf(fd, "%s", kind) == 1 && n_cmds < MAX_CMDS) begin
            if (kind == "//") begin
                n = $fgets(rest, fd);  // column notes
            end else begin
                n = $fscanf(fd, "%h %h %h %h %h", tag, op, addr, data, expv);
                if (n != 5) begin
                    $display("case line %0d is missing fields", n_cmds + 1);
                    errors++;
                end
                cmd_kind[n_cmds] = kind;
                cmd_tag[n_cmds]  = tag;
                cmd_op[n_cmds]   = op;
                cmd_addr[n_cmds] = addr;
                cmd_data[n_cmds] = data;
                cmd_exp[n_cmds]  = expv;
                n_cmds++;
            end
            kind = '0;
        end
        $fclose(fd);
    endtask

    task automatic run_command(input int i);
        case (cmd_kind[i])
            "issue": begin
                issue_op   = mem_op_t'(cmd_op[i][3:0]);
                issue_tag  = rob_tag_t'(cmd_tag[i]);
                issue_addr = cmd_addr[i];
                issue_data = (cmd_exp[i] == 32'd1) ? mem_word_t'($random(seed)) : cmd_data[i];
            end
            "commit": commit_tag = rob_tag_t'(cmd_tag[i]);
            "fetch": begin
                fetch_req = 1'b1;
                fetch_pc  = cmd_addr[i];
            end
            "stall": begin
                check_level("fetch_full", fetch_full, cmd_exp[i][0]);
                stall = cmd_data[i][0];
            end
            "wait": begin
                if (cmd_data[i] == 32'd0) begin
                    while (pending() != 0) @(posedge clk);
                end else begin
                    repeat (cmd_data[i]) @(posedge clk);
                end
            end
            "expect_load": begin
                load_tags.push_back(rob_tag_t'(cmd_tag[i]));
                load_values.push_back(cmd_exp[i]);
            end
            "expect_store": store_tags.push_back(rob_tag_t'(cmd_tag[i]));
            "expect_ins": ins_values.push_back(cmd_exp[i]);
            default: begin
                $display("unknown command on case line %0d", i + 1);
                errors++;
            end
        endcase
    endtask

    task automatic clear_pulses();
        issue_op   = MEM_NONE;
        commit_tag = TAG_NONE;
        fetch_req  = 1'b0;
    endtask

    initial begin
        rst        = 1'b0;
        issue_op   = MEM_NONE;
        issue_tag  = TAG_NONE;
        issue_addr = '0;
        issue_data = '0;
        commit_tag = TAG_NONE;
        fetch_req  = 1'b0;
        fetch_pc   = '0;
        stall      = 1'b0;
        read_cases();
        if (n_cmds == 0) begin
            $display("no commands read from the case file");
            errors++;
        end
        cases_loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < n_cmds; i++) begin
            @(posedge clk);
            #1;
            clear_pulses();
            run_command(i);
        end
        @(posedge clk);
        #1;
        clear_pulses();
        repeat (20) @(posedge clk);  // room for stray completions
        $display("errors %0d missing %0d", errors, pending());
        if (errors == 0 && pending() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (cases_loaded);
        repeat (20 * n_cmds + 200) @(posedge clk);
        $display("run timed out after %0d cycles", 20 * n_cmds + 200);
        $display("errors %0d missing %0d", errors, pending());
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: verif/mem_cases.txt
// kind tag op addr data expect (hex); op 1 LB 2 LH 3 LW 4 LBU 5 LHU 6 SB 7 SH 8 SW
// wait 0 drains, n idles n cycles; issue expect 1 = random data; stall expect = fetch_full
issue 1 8 100 8899a1b2 0
issue 2 7 200 0000c435 0
issue 3 1 100 0 0
issue 4 2 102 0 0
issue 5 5 200 0 0
issue 6 4 201 0 0
expect_store 1 0 0 0 0
expect_store 2 0 0 0 0
expect_load 3 0 0 0 ffffffb2
expect_load 4 0 0 0 ffff8899
expect_load 5 0 0 0 0000c435
expect_load 6 0 0 0 000000c4
commit 1 0 0 0 0
commit 2 0 0 0 0
commit 3 0 0 0 0
commit 4 0 0 0 0
commit 5 0 0 0 0
commit 6 0 0 0 0
wait 0 0 0 0 0
issue 1 6 300 0 1
issue 2 3 100 0 0
expect_store 1 0 0 0 0
expect_load 2 0 0 0 8899a1b2
expect_ins 0 0 0 0 8899a1b2
expect_ins 0 0 0 0 0000c435
fetch 0 0 100 0 0
commit 1 0 0 0 0
fetch 0 0 200 0 0
commit 7 0 0 0 0
commit 2 0 0 0 0
wait 0 0 0 0 0
stall 0 0 0 1 0
expect_ins 0 0 0 0 8899a1b2
expect_ins 0 0 0 0 0000c435
expect_ins 0 0 0 0 8899a1b2
expect_ins 0 0 0 0 0000c435
expect_ins 0 0 0 0 8899a1b2
expect_ins 0 0 0 0 0000c435
expect_ins 0 0 0 0 8899a1b2
fetch 0 0 100 0 0
fetch 0 0 200 0 0
fetch 0 0 100 0 0
fetch 0 0 200 0 0
fetch 0 0 100 0 0
fetch 0 0 200 0 0
fetch 0 0 100 0 0
wait 0 0 0 2 0
stall 0 0 0 0 1
wait 0 0 0 0 0
stall 0 0 0 0 0

// File: verilog.f
+incdir+logic
logic/lsu_pkg.sv
logic/fetch_pkg.sv
logic/ring_queue.sv
logic/lsb_entry_table.sv
logic/byte_mem_sequencer.sv
logic/byte_ram.sv
logic/mem_subsystem_top.sv
verif/mem_subsystem_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := mem_subsystem_tb
LINT_TOP   := mem_subsystem_top
FILELIST   := verilog.f
FLAGS      := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
